// ==== rtl/codebook_pkg.sv ====
package codebook_pkg;

  // bus and path geometry
  localparam int WORD_W         = 32;
  localparam int PATH_W         = 128;
  localparam int IDX_W          = 6;                        // 64 character indices
  localparam int WORDS_PER_PATH = PATH_W / WORD_W;          // 4 words per path
  localparam int WCNT_W         = $clog2(WORDS_PER_PATH);   // word counter width
  localparam int MEM_WORDS      = WORDS_PER_PATH << IDX_W;  // 256 words in sram
  localparam int MEM_AW         = $clog2(MEM_WORDS);        // word index width

  // sram window start, byte address
  localparam logic [WORD_W-1:0] BASE_ADDR = 32'h3300_0000;

  // busy window of the word port
  localparam int                BUSY_W   = 2;
  localparam logic [BUSY_W-1:0] SRAM_LAT = 2'd2;           // busy cycles per access

  // operation carried out by the store
  typedef enum logic [1:0] {
    MODE_IDLE  = 2'd0,
    MODE_CLEAR = 2'd1,  // zero the whole region
    MODE_WRITE = 2'd2,  // store one path
    MODE_READ  = 2'd3   // fetch one path
  } mode_t;

endpackage

// ==== rtl/sram_word_port.sv ====
module sram_word_port (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [codebook_pkg::WORD_W-1:0]  addr_i,
  input  logic [codebook_pkg::WORD_W-1:0]  wdata_i,
  output logic                             busy_o,
  output logic [codebook_pkg::WORD_W-1:0]  rdata_o
);

  logic [codebook_pkg::WORD_W-1:0] mem [codebook_pkg::MEM_WORDS];

  logic [codebook_pkg::BUSY_W-1:0] busy_cnt;   // cycles of busy left
  logic [codebook_pkg::WORD_W-1:0] offset;     // byte offset into the region
  logic [codebook_pkg::MEM_AW-1:0] word_idx;
  logic [codebook_pkg::MEM_AW-1:0] rd_idx_q;   // word index of the running access
  logic                            take;
  logic                            busy_end;

  assign offset   = addr_i - codebook_pkg::BASE_ADDR;
  assign word_idx = offset[codebook_pkg::MEM_AW+1:2];  // drop byte lanes

  assign busy_o   = (busy_cnt != '0);
  assign take     = req_i && !busy_o;               // access accepted this edge
  assign busy_end = (busy_cnt == codebook_pkg::BUSY_W'(1));

  // busy window
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_cnt <= '0;
    end else if (take) begin
      busy_cnt <= codebook_pkg::SRAM_LAT;
    end else if (busy_o) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  // storage array, write lands at acceptance
  always_ff @(posedge clk) begin
    if (take && we_i) begin
      mem[word_idx] <= wdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rd_idx_q <= word_idx;
    end
  end

  // read word shows up in the cycle busy falls
  always_ff @(posedge clk) begin
    if (busy_end) begin
      rdata_o <= mem[rd_idx_q];
    end
  end

endmodule

// ==== rtl/codebook_store.sv ====
module codebook_store (
  input  logic                             clk,
  input  logic                             rst,

  // path side, from the controller
  input  codebook_pkg::mode_t              mode_i,
  input  logic [codebook_pkg::IDX_W-1:0]   index_i,
  input  logic [codebook_pkg::PATH_W-1:0]  path_i,
  input  logic                             start_i,
  output logic                             done_o,
  output logic [codebook_pkg::PATH_W-1:0]  rdata_o,

  // word bus to the sram port
  output logic                             req_o,
  output logic                             we_o,
  output logic [codebook_pkg::WORD_W-1:0]  addr_o,
  output logic [codebook_pkg::WORD_W-1:0]  wdata_o,
  input  logic                             busy_i,
  input  logic [codebook_pkg::WORD_W-1:0]  word_rdata_i
);

  logic                             active;     // operation in flight
  logic                             waiting;    // word issued, waiting for busy to fall
  logic                             busy_q;     // busy one cycle ago
  logic                             done_q;
  logic [codebook_pkg::WCNT_W-1:0]  word_cnt;   // word within the path
  logic [codebook_pkg::MEM_AW-1:0]  clr_cnt;    // word being cleared
  logic [codebook_pkg::PATH_W-1:0]  rdata_q;

  logic                             clearing;
  logic                             reading;
  logic                             take;
  logic                             fall;
  logic                             last;
  logic [codebook_pkg::WORD_W-1:0]  path_off;
  logic [codebook_pkg::WORD_W-1:0]  clr_off;
  int                               slot;       // word slot inside the path, msw first

  assign clearing = (mode_i == codebook_pkg::MODE_CLEAR);
  assign reading  = (mode_i == codebook_pkg::MODE_READ);

  // first word goes out together with start, later ones right after each fall
  assign req_o = active ? !waiting : (start_i && mode_i != codebook_pkg::MODE_IDLE);
  assign we_o  = !reading;
  assign take  = req_o && !busy_i;
  assign fall  = busy_q && !busy_i;           // access just completed

  assign last = clearing ? (int'(clr_cnt) == codebook_pkg::MEM_WORDS - 1)
                         : (int'(word_cnt) == codebook_pkg::WORDS_PER_PATH - 1);

  // 16 bytes per path, 4 bytes per word
  assign path_off = {{(codebook_pkg::WORD_W - codebook_pkg::IDX_W - 4){1'b0}},
                     index_i, word_cnt, 2'b00};
  assign clr_off  = {{(codebook_pkg::WORD_W - codebook_pkg::MEM_AW - 2){1'b0}},
                     clr_cnt, 2'b00};

  assign addr_o = codebook_pkg::BASE_ADDR + (clearing ? clr_off : path_off);

  assign slot = codebook_pkg::WORDS_PER_PATH - 1 - int'(word_cnt);

  always_comb begin
    wdata_o = '0;  // clear writes zero
    if (mode_i == codebook_pkg::MODE_WRITE) begin
      wdata_o = path_i[slot*codebook_pkg::WORD_W +: codebook_pkg::WORD_W];
    end
  end

  // sequencing of the word accesses
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      active   <= 1'b0;
      waiting  <= 1'b0;
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      word_cnt <= '0;
      clr_cnt  <= '0;
    end else begin
      busy_q <= busy_i;
      done_q <= 1'b0;
      if (take) begin
        active  <= 1'b1;
        waiting <= 1'b1;
      end else if (waiting && fall) begin
        waiting <= 1'b0;
        if (last) begin
          active   <= 1'b0;
          done_q   <= 1'b1;
          word_cnt <= '0;
          clr_cnt  <= '0;
        end else if (clearing) begin
          clr_cnt <= clr_cnt + 1'b1;
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

  // gather read words, first word fills the top quarter
  always_ff @(posedge clk) begin
    if (waiting && fall && reading) begin
      rdata_q[slot*codebook_pkg::WORD_W +: codebook_pkg::WORD_W] <= word_rdata_i;
    end
  end

  assign done_o  = done_q;
  assign rdata_o = rdata_q;

endmodule

// ==== rtl/codebook_ctrl.sv ====
module codebook_ctrl (
  input  logic                             clk,
  input  logic                             rst,

  // request side
  input  logic                             wr_valid_i,
  input  logic [codebook_pkg::IDX_W-1:0]   wr_index_i,
  input  logic [codebook_pkg::PATH_W-1:0]  wr_path_i,
  output logic                             wr_ready_o,
  input  logic                             rd_valid_i,
  input  logic [codebook_pkg::IDX_W-1:0]   rd_index_i,
  output logic                             rd_ready_o,
  output logic                             init_done_o,
  output logic                             rd_data_valid_o,
  output logic [codebook_pkg::PATH_W-1:0]  rd_data_o,

  // store side
  output codebook_pkg::mode_t              mode_o,
  output logic [codebook_pkg::IDX_W-1:0]   index_o,
  output logic [codebook_pkg::PATH_W-1:0]  path_o,
  output logic                             start_o,
  input  logic                             done_i,
  input  logic [codebook_pkg::PATH_W-1:0]  rdata_i
);

  typedef enum logic [1:0] {
    ST_INIT,   // kick off the clear
    ST_CLEAR,  // clear running
    ST_IDLE,   // ready for a request
    ST_RUN     // path write or read running
  } state_t;

  state_t state;

  // write wins when both are valid
  assign wr_ready_o = (state == ST_IDLE);
  assign rd_ready_o = (state == ST_IDLE) && !wr_valid_i;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state           <= ST_INIT;
      mode_o          <= codebook_pkg::MODE_IDLE;
      start_o         <= 1'b0;
      init_done_o     <= 1'b0;
      rd_data_valid_o <= 1'b0;
    end else begin
      start_o         <= 1'b0;  // single cycle pulses
      rd_data_valid_o <= 1'b0;
      case (state)
        ST_INIT: begin
          mode_o  <= codebook_pkg::MODE_CLEAR;
          start_o <= 1'b1;
          state   <= ST_CLEAR;
        end
        ST_CLEAR: begin
          if (done_i) begin
            mode_o      <= codebook_pkg::MODE_IDLE;
            init_done_o <= 1'b1;  // stays high from here on
            state       <= ST_IDLE;
          end
        end
        ST_IDLE: begin
          if (wr_valid_i) begin
            mode_o  <= codebook_pkg::MODE_WRITE;
            start_o <= 1'b1;
            state   <= ST_RUN;
          end else if (rd_valid_i) begin
            mode_o  <= codebook_pkg::MODE_READ;
            start_o <= 1'b1;
            state   <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (done_i) begin
            rd_data_valid_o <= (mode_o == codebook_pkg::MODE_READ);
            mode_o          <= codebook_pkg::MODE_IDLE;
            state           <= ST_IDLE;
          end
        end
        default: state <= ST_INIT;
      endcase
    end
  end

  // request payload, held for the store until done
  always_ff @(posedge clk) begin
    if (state == ST_IDLE) begin
      if (wr_valid_i) begin
        index_o <= wr_index_i;
        path_o  <= wr_path_i;
      end else if (rd_valid_i) begin
        index_o <= rd_index_i;
      end
    end
  end

  // returned path
  always_ff @(posedge clk) begin
    if (state == ST_RUN && done_i && mode_o == codebook_pkg::MODE_READ) begin
      rd_data_o <= rdata_i;
    end
  end

endmodule

// ==== rtl/codebook_top.sv ====
module codebook_top (
  input  logic                             clk,
  input  logic                             rst,

  input  logic                             wr_valid_i,
  input  logic [codebook_pkg::IDX_W-1:0]   wr_index_i,
  input  logic [codebook_pkg::PATH_W-1:0]  wr_path_i,
  output logic                             wr_ready_o,

  input  logic                             rd_valid_i,
  input  logic [codebook_pkg::IDX_W-1:0]   rd_index_i,
  output logic                             rd_ready_o,

  output logic                             init_done_o,
  output logic                             rd_data_valid_o,
  output logic [codebook_pkg::PATH_W-1:0]  rd_data_o
);

  // controller to store
  codebook_pkg::mode_t              mode;
  logic [codebook_pkg::IDX_W-1:0]   index;
  logic [codebook_pkg::PATH_W-1:0]  path;
  logic                             start;
  logic                             done;
  logic [codebook_pkg::PATH_W-1:0]  path_rdata;

  // store to sram word bus
  logic                             req;
  logic                             we;
  logic [codebook_pkg::WORD_W-1:0]  addr;
  logic [codebook_pkg::WORD_W-1:0]  wdata;
  logic                             busy;
  logic [codebook_pkg::WORD_W-1:0]  word_rdata;

  codebook_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .wr_valid_i      (wr_valid_i),
    .wr_index_i      (wr_index_i),
    .wr_path_i       (wr_path_i),
    .wr_ready_o      (wr_ready_o),
    .rd_valid_i      (rd_valid_i),
    .rd_index_i      (rd_index_i),
    .rd_ready_o      (rd_ready_o),
    .init_done_o     (init_done_o),
    .rd_data_valid_o (rd_data_valid_o),
    .rd_data_o       (rd_data_o),
    .mode_o          (mode),
    .index_o         (index),
    .path_o          (path),
    .start_o         (start),
    .done_i          (done),
    .rdata_i         (path_rdata)
  );

  codebook_store u_store (
    .clk          (clk),
    .rst          (rst),
    .mode_i       (mode),
    .index_i      (index),
    .path_i       (path),
    .start_i      (start),
    .done_o       (done),
    .rdata_o      (path_rdata),
    .req_o        (req),
    .we_o         (we),
    .addr_o       (addr),
    .wdata_o      (wdata),
    .busy_i       (busy),
    .word_rdata_i (word_rdata)
  );

  sram_word_port u_sram (
    .clk     (clk),
    .rst     (rst),
    .req_i   (req),
    .we_i    (we),
    .addr_i  (addr),
    .wdata_i (wdata),
    .busy_o  (busy),
    .rdata_o (word_rdata)
  );

endmodule

// ==== tests/tb_codebook.sv ====
module tb_codebook;
  timeunit 1ns;
  timeprecision 1ps;

  // cycles of one word access in the store, busy window plus issue and fall detect
  localparam int WORD_CYCLES    = int'(codebook_pkg::SRAM_LAT) + 2;
  localparam int PATH_CYCLES    = codebook_pkg::WORDS_PER_PATH * WORD_CYCLES;
  localparam int CLEAR_CYCLES   = codebook_pkg::MEM_WORDS * WORD_CYCLES;
  localparam int N_INDEX        = 1 << codebook_pkg::IDX_W;
  localparam int N_RANDOM       = 200;
  // full sweep, word order, overwrite, random, write-first pairs
  localparam int N_OPS          = N_INDEX + 6 + 7 + N_RANDOM + 4;
  localparam int TIMEOUT_CYCLES = 4 * (CLEAR_CYCLES + N_OPS * PATH_CYCLES);

  logic                             clk;
  logic                             rst;
  logic                             wr_valid_i;
  logic [codebook_pkg::IDX_W-1:0]   wr_index_i;
  logic [codebook_pkg::PATH_W-1:0]  wr_path_i;
  logic                             wr_ready_o;
  logic                             rd_valid_i;
  logic [codebook_pkg::IDX_W-1:0]   rd_index_i;
  logic                             rd_ready_o;
  logic                             init_done_o;
  logic                             rd_data_valid_o;
  logic [codebook_pkg::PATH_W-1:0]  rd_data_o;

  logic [codebook_pkg::PATH_W-1:0]  ref_mem [N_INDEX];   // last path written per index
  bit                               written [N_INDEX];
  logic [codebook_pkg::IDX_W-1:0]   exp_idx_q [$];       // indices of reads in flight
  int                               seed;
  int                               cycle_cnt;
  int                               reads_issued;
  int                               reads_checked;
  bit                               init_seen;

  codebook_top uut (
    .clk             (clk),
    .rst             (rst),
    .wr_valid_i      (wr_valid_i),
    .wr_index_i      (wr_index_i),
    .wr_path_i       (wr_path_i),
    .wr_ready_o      (wr_ready_o),
    .rd_valid_i      (rd_valid_i),
    .rd_index_i      (rd_index_i),
    .rd_ready_o      (rd_ready_o),
    .init_done_o     (init_done_o),
    .rd_data_valid_o (rd_data_valid_o),
    .rd_data_o       (rd_data_o)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_path(input logic [codebook_pkg::PATH_W-1:0] got,
                            input logic [codebook_pkg::PATH_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s expected %h got %h", $time, what, exp, got));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s expected %b got %b", $time, what, exp, got));
    end
  endtask

  // zero until written, then the newest path
  function automatic logic [codebook_pkg::PATH_W-1:0] expected_path(
      input logic [codebook_pkg::IDX_W-1:0] idx);
    if (!written[idx]) begin
      return '0;
    end else begin
      return ref_mem[idx];
    end
  endfunction

  task automatic record_write(input logic [codebook_pkg::IDX_W-1:0] idx,
                              input logic [codebook_pkg::PATH_W-1:0] path);
    ref_mem[idx] = path;
    written[idx] = 1'b1;
  endtask

  // called one step after the falling edge that follows acceptance
  task automatic wait_op_done(input bit is_read);
    int n;
    n = 0;
    while (is_read ? !rd_data_valid_o : !wr_ready_o) begin
      check_bit(wr_ready_o, 1'b0, "wr_ready_o during a path operation");
      check_bit(rd_ready_o, 1'b0, "rd_ready_o during a path operation");
      n++;
      @(negedge clk);
      #1;
    end
    if (n < PATH_CYCLES) begin
      abort_run($sformatf("path operation finished after %0d cycles, faster than %0d",
                          n, PATH_CYCLES));
    end
  endtask

  task automatic write_path(input logic [codebook_pkg::IDX_W-1:0] idx,
                            input logic [codebook_pkg::PATH_W-1:0] path);
    @(negedge clk);
    wr_valid_i = 1'b1;
    wr_index_i = idx;
    wr_path_i  = path;
    #1;
    while (!wr_ready_o) begin  // hold valid until the DUT takes it
      @(negedge clk);
      #1;
    end
    record_write(idx, path);  // taken on the coming rising edge
    @(negedge clk);
    wr_valid_i = 1'b0;
    #1;
    wait_op_done(1'b0);
  endtask

  task automatic read_path(input logic [codebook_pkg::IDX_W-1:0] idx);
    @(negedge clk);
    rd_valid_i = 1'b1;
    rd_index_i = idx;
    #1;
    while (!rd_ready_o) begin
      @(negedge clk);
      #1;
    end
    exp_idx_q.push_back(idx);
    reads_issued++;
    @(negedge clk);
    rd_valid_i = 1'b0;
    #1;
    wait_op_done(1'b1);
  endtask

  // both requests raised together, the write has to go first
  task automatic write_then_read(input logic [codebook_pkg::IDX_W-1:0] wr_idx,
                                 input logic [codebook_pkg::PATH_W-1:0] path,
                                 input logic [codebook_pkg::IDX_W-1:0] rd_idx);
    @(negedge clk);
    wr_valid_i = 1'b1;
    wr_index_i = wr_idx;
    wr_path_i  = path;
    rd_valid_i = 1'b1;
    rd_index_i = rd_idx;
    #1;
    while (!wr_ready_o) begin
      @(negedge clk);
      #1;
    end
    check_bit(rd_ready_o, 1'b0, "rd_ready_o while a write is also valid");
    record_write(wr_idx, path);
    @(negedge clk);
    wr_valid_i = 1'b0;  // read stays valid through the write
    #1;
    wait_op_done(1'b0);
    check_bit(rd_ready_o, 1'b1, "rd_ready_o once the write finished");
    exp_idx_q.push_back(rd_idx);
    reads_issued++;
    @(negedge clk);
    rd_valid_i = 1'b0;
    #1;
    wait_op_done(1'b1);
  endtask

  // checks every returned path against the reference
  always begin : compare_reads
    logic [codebook_pkg::IDX_W-1:0] idx;
    @(negedge clk);
    #1;
    if (rd_data_valid_o) begin
      if (exp_idx_q.size() == 0) begin
        abort_run("read result arrived without a pending read request");
      end else begin
        idx = exp_idx_q.pop_front();
        check_path(rd_data_o, expected_path(idx), $sformatf("path at index %0d", idx));
        reads_checked++;
      end
    end
  end

  // ready must stay low during the clear, init_done never falls
  always begin : watch_init
    @(negedge clk);
    #1;
    if (!rst) begin
      if (init_seen) begin
        check_bit(init_done_o, 1'b1, "init_done_o after the clear finished");
      end else if (!init_done_o) begin
        check_bit(wr_ready_o, 1'b0, "wr_ready_o during the clear");
        check_bit(rd_ready_o, 1'b0, "rd_ready_o during the clear");
      end
      if (init_done_o) begin
        init_seen = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: the test did not finish within %0d clock cycles",
                          TIMEOUT_CYCLES));
    end
  end

  initial begin : stimulus
    int                              i;
    logic [31:0]                     rnd;
    logic [codebook_pkg::IDX_W-1:0]  idx;
    logic [codebook_pkg::PATH_W-1:0] path;

    seed          = 32'heb1d587a;
    clk           = 1'b0;
    rst           = 1'b1;
    wr_valid_i    = 1'b0;
    wr_index_i    = '0;
    wr_path_i     = '0;
    rd_valid_i    = 1'b0;
    rd_index_i    = '0;
    cycle_cnt     = 0;
    reads_issued  = 0;
    reads_checked = 0;
    init_seen     = 1'b0;
    for (i = 0; i < N_INDEX; i++) begin
      ref_mem[i] = '0;
      written[i] = 1'b0;
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // whole region reads as zero after the clear
    while (!init_done_o) begin
      @(negedge clk);
      #1;
    end
    // init_done_o and both ready outputs rise together at the end of the clear
    check_bit(wr_ready_o, 1'b1, "wr_ready_o once init_done_o is high");
    check_bit(rd_ready_o, 1'b1, "rd_ready_o once init_done_o is high");
    for (i = 0; i < N_INDEX; i++) begin
      read_path(codebook_pkg::IDX_W'(i));
    end

    // distinct quarters expose a swapped word order
    write_path(6'd5,  {32'h0123_4567, 32'h89ab_cdef, 32'hfedc_ba98, 32'h7654_3210});
    write_path(6'd0,  {32'hffff_0000, 32'h0000_ffff, 32'haaaa_5555, 32'h5555_aaaa});
    write_path(6'd63, {32'h1111_1111, 32'h2222_2222, 32'h3333_3333, 32'h4444_4444});
    read_path(6'd5);
    read_path(6'd0);
    read_path(6'd63);

    // overwrite the middle one, neighbours keep their paths
    write_path(6'd19, {32'h1919_0001, 32'h1919_0002, 32'h1919_0003, 32'h1919_0004});
    write_path(6'd20, {32'h2020_0001, 32'h2020_0002, 32'h2020_0003, 32'h2020_0004});
    write_path(6'd21, {32'h2121_0001, 32'h2121_0002, 32'h2121_0003, 32'h2121_0004});
    write_path(6'd20, {32'hdead_beef, 32'hcafe_f00d, 32'h0bad_c0de, 32'h1234_abcd});
    read_path(6'd19);
    read_path(6'd20);
    read_path(6'd21);

    for (i = 0; i < N_RANDOM; i++) begin
      rnd = $random(seed);
      idx = rnd[codebook_pkg::IDX_W-1:0];
      if (rnd[16]) begin
        path = {$random(seed), $random(seed), $random(seed), $random(seed)};
        write_path(idx, path);
      end else begin
        read_path(idx);
      end
    end

    // same index shows the new path, so the write went first
    write_then_read(6'd33, {32'h3333_aaaa, 32'h3333_bbbb, 32'h3333_cccc, 32'h3333_dddd},
                    6'd33);
    write_then_read(6'd40, {32'h4040_0101, 32'h4040_0202, 32'h4040_0303, 32'h4040_0404},
                    6'd41);

    repeat (2) @(negedge clk);
    if (reads_checked != reads_issued || exp_idx_q.size() != 0) begin
      abort_run($sformatf("only %0d of %0d read requests returned a result",
                          reads_checked, reads_issued));
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== codebook_sram.f ====
rtl/codebook_pkg.sv
rtl/sram_word_port.sv
rtl/codebook_store.sv
rtl/codebook_ctrl.sv
rtl/codebook_top.sv
tests/tb_codebook.sv

// ==== Bender.yml ====
package:
  name: codebook_sram

sources:
  # package first, then leaf modules, then the top level
  - rtl/codebook_pkg.sv
  - rtl/sram_word_port.sv
  - rtl/codebook_store.sv
  - rtl/codebook_ctrl.sv
  - rtl/codebook_top.sv
  - target: test
    files:
      - tests/tb_codebook.sv
